//--- Makefile
# Verilator build and run of the csr testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/csr_properties.sv
/*
 * csr properties: response stability, request hold-off and
 * strobe exclusion, bound into csr_top
 */
`timescale 1ns/1ps

module csr_properties
  import csr_pkg::*;
(
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_req_ready,
  input logic              i_rsp_valid,
  input logic              i_rsp_ready,
  input logic [CSR_DW-1:0] i_rsp_rdata,
  input logic              i_rsp_err,
  input logic              i_wen,
  input logic              i_ren
);

  // stalled response keeps valid and payload
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rsp_valid && !i_rsp_ready) |=>
      (i_rsp_valid && $stable(i_rsp_rdata) && $stable(i_rsp_err)))
    else $error("response changed while stalled");

  // no new request while the slot is full
  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_rsp_valid |-> !i_req_ready)
    else $error("request ready high while a response is held");

  // strobes exclusive, and only ever into an empty response slot
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0({i_wen, i_ren, i_rsp_valid}))
    else $error("strobes overlap each other or a held response");

endmodule

bind csr_top csr_properties csr_properties_inst (
  .i_clk, .i_rst_n,
  .i_req_ready(o_req_ready), .i_rsp_valid(o_rsp_valid), .i_rsp_ready,
  .i_rsp_rdata(o_rsp_rdata), .i_rsp_err(o_rsp_err),
  .i_wen(bus_wen), .i_ren(bus_ren)
);

//--- sim/csr_tb.sv
/*
 * csr testbench: table of requests with random response
 * back-pressure, shadow model for irq and ctrl
 */
`timescale 1ns/1ps

module csr_tb
  import csr_pkg::*;
();

  localparam int TIMEOUT = 20;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_req_valid;
  logic              o_req_ready;
  logic              i_req_write;
  logic [CSR_AW-1:0] i_req_addr;
  logic [CSR_DW-1:0] i_req_wdata;
  logic              o_rsp_valid;
  logic              i_rsp_ready;
  logic [CSR_DW-1:0] o_rsp_rdata;
  logic              o_rsp_err;
  logic              i_cfg_mode;
  logic              i_test_mode;
  logic [CSR_DW-1:0] i_evt;
  logic [CSR_DW-1:0] o_ctrl;
  logic              o_irq;

  // stimulus table, one slot per entry
  string             t_name[$];
  bit                t_wr[$];
  logic [CSR_AW-1:0] t_addr[$];
  logic [CSR_DW-1:0] t_data[$];
  bit                t_cfg[$];
  bit                t_test[$];
  logic [CSR_DW-1:0] t_evt[$];
  logic [CSR_DW-1:0] t_exp[$];
  bit                t_err[$];

  // shadow registers
  logic [CSR_DW-1:0] m_ctrl = '0;
  logic [CSR_DW-1:0] m_en = '0;
  logic [CSR_DW-1:0] m_status = '0;

  logic [31:0] lfsr;
  int          err_count = 0;
  int          timeout_count = 0;
  int          rsp_count = 0;

  csr_top csr_top_inst (
    .i_clk, .i_rst_n,
    .i_req_valid, .o_req_ready, .i_req_write, .i_req_addr, .i_req_wdata,
    .o_rsp_valid, .i_rsp_ready, .o_rsp_rdata, .o_rsp_err,
    .i_cfg_mode, .i_test_mode, .i_evt, .o_ctrl, .o_irq
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ====================================================================
  // helpers
  // ====================================================================

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic int take_bits(input int n);
    int bits;
    bits = 0;
    for (int b = 0; b < n; b++) begin
      bits = (bits << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  task automatic add_entry(input string name, input bit wr, input logic [CSR_AW-1:0] addr,
                           input logic [CSR_DW-1:0] data, input bit cfg, input bit test,
                           input logic [CSR_DW-1:0] evt, input logic [CSR_DW-1:0] exp,
                           input bit err);
    t_name.push_back(name);
    t_wr.push_back(wr);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_cfg.push_back(cfg);
    t_test.push_back(test);
    t_evt.push_back(evt);
    t_exp.push_back(exp);
    t_err.push_back(err);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [CSR_DW-1:0] exp, input logic [CSR_DW-1:0] act);
    assert (act === exp) else begin
      $display("** Error: %s: %s expected 8'h%02h, actual 8'h%02h", name, what, exp, act);
      err_count++;
    end
  endtask

  // events land before the access, a set beats a clear
  task automatic model_access(input int k);
    logic any_mode;
    any_mode = t_cfg[k] | t_test[k];
    m_status = m_status | t_evt[k];
    if (t_wr[k] && any_mode) begin
      case (t_addr[k])
        ADDR_CTRL:       m_ctrl = t_data[k];
        ADDR_IRQ_EN:     m_en = t_data[k];
        ADDR_IRQ_STATUS: m_status = (m_status & ~t_data[k]) | t_evt[k];
        default:         ;
      endcase
    end
  endtask

  // ====================================================================
  // one table entry: request, response, checks, release
  // ====================================================================
  task automatic apply_entry(input int k);
    int cycles;
    int stall;
    stall = take_bits(2);
    @(posedge i_clk);
    i_req_valid <= 1'b1;
    i_req_write <= t_wr[k];
    i_req_addr  <= t_addr[k];
    i_req_wdata <= t_data[k];
    i_cfg_mode  <= t_cfg[k];
    i_test_mode <= t_test[k];
    i_evt       <= t_evt[k];
    // ready seen low edge ahead of the transfer edge
    cycles = 0;
    @(negedge i_clk);
    while (!o_req_ready) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: request %s was never accepted", t_name[k]);
        timeout_count++;
        return;
      end
      @(negedge i_clk);
    end
    @(posedge i_clk);
    i_req_valid <= 1'b0;
    // event pulse covers the transfer edge and the access edge only
    @(posedge i_clk);
    i_evt <= '0;
    cycles = 0;
    @(negedge i_clk);
    while (!o_rsp_valid) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: no response arrived for %s", t_name[k]);
        timeout_count++;
        return;
      end
      @(negedge i_clk);
    end
    model_access(k);
    check_value(t_name[k], "rdata", t_exp[k], o_rsp_rdata);
    check_value(t_name[k], "err", {7'b0, t_err[k]}, {7'b0, o_rsp_err});
    check_value(t_name[k], "irq", {7'b0, |(m_status & m_en)}, {7'b0, o_irq});
    check_value(t_name[k], "ctrl", m_ctrl, o_ctrl);
    // stall 0 to 3 extra cycles
    repeat (stall) @(posedge i_clk);
    @(posedge i_clk);
    i_rsp_ready <= 1'b1;
    @(posedge i_clk);
    i_rsp_ready <= 1'b0;
    @(negedge i_clk);
    assert (!o_rsp_valid) else begin
      $display("Response for %s was still held after its transfer", t_name[k]);
      err_count++;
    end
  endtask

  // one count per response handshake
  always @(negedge i_clk) begin
    if (i_rst_n && o_rsp_valid && i_rsp_ready) begin
      rsp_count++;
    end
  end

  initial begin
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_rsp_ready = 1'b0;
    i_cfg_mode  = 1'b0;
    i_test_mode = 1'b0;
    i_evt       = '0;
    lfsr        = 32'h8b26;
    // name, wr, addr, wdata, cfg, test, evt, exp rdata, exp err
    add_entry("ctrl after reset", 0, ADDR_CTRL, 8'h00, 1, 0, 8'h00, 8'h00, 0);
    add_entry("irq_en after reset", 0, ADDR_IRQ_EN, 8'h00, 1, 0, 8'h00, 8'h00, 0);
    add_entry("scratch after reset", 0, ADDR_SCRATCH, 8'h00, 1, 0, 8'h00, 8'h00, 0);
    add_entry("status after reset", 0, ADDR_IRQ_STATUS, 8'h00, 1, 0, 8'h00, 8'h00, 0);
    add_entry("id after reset", 0, ADDR_ID, 8'h00, 1, 0, 8'h00, 8'hA5, 0);
    add_entry("ctrl cfg write", 1, ADDR_CTRL, 8'h3C, 1, 0, 8'h00, 8'h00, 0);
    add_entry("ctrl readback", 0, ADDR_CTRL, 8'h00, 1, 0, 8'h00, 8'h3C, 0);
    add_entry("irq_en cfg write", 1, ADDR_IRQ_EN, 8'h0F, 1, 0, 8'h00, 8'h00, 0);
    add_entry("irq_en readback", 0, ADDR_IRQ_EN, 8'h00, 1, 0, 8'h00, 8'h0F, 0);
    add_entry("ctrl write no mode", 1, ADDR_CTRL, 8'h77, 0, 0, 8'h00, 8'h00, 0);
    add_entry("ctrl read no mode", 0, ADDR_CTRL, 8'h00, 0, 0, 8'h00, 8'h00, 0);
    add_entry("ctrl kept", 0, ADDR_CTRL, 8'h00, 1, 0, 8'h00, 8'h3C, 0);
    add_entry("scratch test write", 1, ADDR_SCRATCH, 8'h5A, 0, 1, 8'h00, 8'h00, 0);
    add_entry("scratch readback", 0, ADDR_SCRATCH, 8'h00, 1, 0, 8'h00, 8'h5A, 0);
    add_entry("scratch cfg write", 1, ADDR_SCRATCH, 8'h11, 1, 0, 8'h00, 8'h00, 0);
    add_entry("scratch kept", 0, ADDR_SCRATCH, 8'h00, 0, 1, 8'h00, 8'h5A, 0);
    add_entry("status event set", 0, ADDR_IRQ_STATUS, 8'h00, 1, 0, 8'h81, 8'h81, 0);
    add_entry("status clear bit 0", 1, ADDR_IRQ_STATUS, 8'h01, 1, 0, 8'h00, 8'h00, 0);
    add_entry("status after clear", 0, ADDR_IRQ_STATUS, 8'h00, 1, 0, 8'h00, 8'h80, 0);
    add_entry("status set vs clear", 1, ADDR_IRQ_STATUS, 8'h80, 1, 0, 8'h84, 8'h00, 0);
    add_entry("status event kept", 0, ADDR_IRQ_STATUS, 8'h00, 1, 0, 8'h00, 8'h84, 0);
    add_entry("irq_en cleared", 1, ADDR_IRQ_EN, 8'h00, 1, 0, 8'h00, 8'h00, 0);
    add_entry("status clear all", 1, ADDR_IRQ_STATUS, 8'hFF, 1, 0, 8'h00, 8'h00, 0);
    add_entry("unmapped read", 0, 8'h14, 8'h00, 1, 0, 8'h00, 8'h00, 1);
    add_entry("unmapped write", 1, 8'h02, 8'hFF, 1, 0, 8'h00, 8'h00, 1);
    add_entry("id test read", 0, ADDR_ID, 8'h00, 0, 1, 8'h00, 8'hA5, 0);
    add_entry("id read no mode", 0, ADDR_ID, 8'h00, 0, 0, 8'h00, 8'h00, 0);
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int k = 0; k < t_name.size(); k++) begin
      apply_entry(k);
      if (timeout_count != 0) break;
    end
    assert (rsp_count == t_name.size()) else begin
      $display("** Error: response count: expected %0d, actual %0d", t_name.size(), rsp_count);
      err_count++;
    end
    $display("Checks failed: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/csr_bus_slave.sv
/*
 * csr bus slave: accepts one request at a time over valid/ready
 * and turns it into a single-cycle read or write strobe
 */
`timescale 1ns/1ps

module csr_bus_slave
  import csr_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_req_valid,
  input  logic              i_req_write,
  input  logic [CSR_AW-1:0] i_req_addr,
  input  logic [CSR_DW-1:0] i_req_wdata,
  input  logic              i_rsp_busy,
  output logic              o_req_ready,
  output logic              o_wen,
  output logic              o_ren,
  output logic [CSR_AW-1:0] o_addr,
  output logic [CSR_DW-1:0] o_wdata
);

  logic strobe_pending;
  logic accept;

  // ====================================================================
  // request handshake
  // ====================================================================

  // a strobe in flight means the response slot is about to fill
  assign strobe_pending = o_wen | o_ren;

  // take nothing while a strobe or a held response is outstanding
  assign o_req_ready = ~strobe_pending & ~i_rsp_busy;
  assign accept      = i_req_valid & o_req_ready;

  // ====================================================================
  // access strobes
  // ====================================================================

  // one cycle high, the cycle after the transfer edge
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wen <= 1'b0;
      o_ren <= 1'b0;
    end else begin
      o_wen <= accept & i_req_write;
      o_ren <= accept & ~i_req_write;
    end
  end

  // request fields, loaded on transfer only
  // held afterwards so decode stays stable during the strobe
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_addr  <= i_req_addr;
      o_wdata <= i_req_wdata;
    end
  end

endmodule

//--- source/csr_pkg.sv
/*
 * csr package: widths, register map, reset values and
 * per-register access permissions for the csr block
 */
package csr_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  localparam int CSR_DW = 8;
  localparam int CSR_AW = 8;

  // ====================================================================
  // register map
  // ====================================================================
  localparam logic [CSR_AW-1:0] ADDR_CTRL       = 8'h00;
  localparam logic [CSR_AW-1:0] ADDR_IRQ_EN     = 8'h04;
  localparam logic [CSR_AW-1:0] ADDR_IRQ_STATUS = 8'h08;
  localparam logic [CSR_AW-1:0] ADDR_SCRATCH    = 8'h0C;
  localparam logic [CSR_AW-1:0] ADDR_ID         = 8'h10;

  // reset values
  localparam logic [CSR_DW-1:0] RST_CTRL       = 8'h00;
  localparam logic [CSR_DW-1:0] RST_IRQ_EN     = 8'h00;
  localparam logic [CSR_DW-1:0] RST_SCRATCH    = 8'h00;
  localparam logic [CSR_DW-1:0] RST_IRQ_STATUS = 8'h00;

  // fixed identification word
  localparam logic [CSR_DW-1:0] CSR_ID_VAL = 8'hA5;

  // ====================================================================
  // access permissions, test/cfg mode x write/read
  // ====================================================================
  localparam bit CTRL_TEST_WR = 1'b1;
  localparam bit CTRL_TEST_RD = 1'b1;
  localparam bit CTRL_CFG_WR  = 1'b1;
  localparam bit CTRL_CFG_RD  = 1'b1;

  localparam bit IRQ_EN_TEST_WR = 1'b1;
  localparam bit IRQ_EN_TEST_RD = 1'b1;
  localparam bit IRQ_EN_CFG_WR  = 1'b1;
  localparam bit IRQ_EN_CFG_RD  = 1'b1;

  localparam bit IRQ_STATUS_TEST_WR = 1'b1;
  localparam bit IRQ_STATUS_TEST_RD = 1'b1;
  localparam bit IRQ_STATUS_CFG_WR  = 1'b1;
  localparam bit IRQ_STATUS_CFG_RD  = 1'b1;

  // scratch is only writable from test mode
  localparam bit SCRATCH_TEST_WR = 1'b1;
  localparam bit SCRATCH_TEST_RD = 1'b1;
  localparam bit SCRATCH_CFG_WR  = 1'b0;
  localparam bit SCRATCH_CFG_RD  = 1'b1;

  // id is read only
  localparam bit ID_TEST_WR = 1'b0;
  localparam bit ID_TEST_RD = 1'b1;
  localparam bit ID_CFG_WR  = 1'b0;
  localparam bit ID_CFG_RD  = 1'b1;

endpackage

//--- source/csr_reg_bank.sv
/*
 * csr register bank: register map, read-data merge, hit flag
 * and interrupt combine
 */
`timescale 1ns/1ps

module csr_reg_bank
  import csr_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wen,
  input  logic              i_ren,
  input  logic [CSR_AW-1:0] i_addr,
  input  logic [CSR_DW-1:0] i_wdata,
  input  logic              i_cfg_mode,
  input  logic              i_test_mode,
  input  logic [CSR_DW-1:0] i_evt,
  output logic [CSR_DW-1:0] o_rdata,
  output logic              o_hit,
  output logic [CSR_DW-1:0] o_ctrl,
  output logic              o_irq
);

  logic [CSR_DW-1:0] ctrl_rdata, irq_en_rdata, status_rdata, scratch_rdata, id_rdata;
  logic              ctrl_hit, irq_en_hit, status_hit, scratch_hit, id_hit;
  logic [CSR_DW-1:0] irq_en_q;
  logic [CSR_DW-1:0] status_q;
  logic              id_rd_ok;

  // ====================================================================
  // register instances
  // ====================================================================
  rw_reg #(
    .REG_ADDR(ADDR_CTRL), .DEFAULT_VAL(RST_CTRL),
    .TEST_WR(CTRL_TEST_WR), .TEST_RD(CTRL_TEST_RD),
    .CFG_WR(CTRL_CFG_WR), .CFG_RD(CTRL_CFG_RD)
  ) ctrl_inst (
    .i_clk, .i_rst_n, .i_wen, .i_ren, .i_cfg_mode, .i_test_mode, .i_addr, .i_wdata,
    .o_rdata(ctrl_rdata), .o_hit(ctrl_hit), .o_q(o_ctrl)
  );

  rw_reg #(
    .REG_ADDR(ADDR_IRQ_EN), .DEFAULT_VAL(RST_IRQ_EN),
    .TEST_WR(IRQ_EN_TEST_WR), .TEST_RD(IRQ_EN_TEST_RD),
    .CFG_WR(IRQ_EN_CFG_WR), .CFG_RD(IRQ_EN_CFG_RD)
  ) irq_en_inst (
    .i_clk, .i_rst_n, .i_wen, .i_ren, .i_cfg_mode, .i_test_mode, .i_addr, .i_wdata,
    .o_rdata(irq_en_rdata), .o_hit(irq_en_hit), .o_q(irq_en_q)
  );

  // scratch value stays internal, only visible through reads
  rw_reg #(
    .REG_ADDR(ADDR_SCRATCH), .DEFAULT_VAL(RST_SCRATCH),
    .TEST_WR(SCRATCH_TEST_WR), .TEST_RD(SCRATCH_TEST_RD),
    .CFG_WR(SCRATCH_CFG_WR), .CFG_RD(SCRATCH_CFG_RD)
  ) scratch_inst (
    .i_clk, .i_rst_n, .i_wen, .i_ren, .i_cfg_mode, .i_test_mode, .i_addr, .i_wdata,
    .o_rdata(scratch_rdata), .o_hit(scratch_hit), .o_q()
  );

  rwc_reg #(
    .REG_ADDR(ADDR_IRQ_STATUS), .DEFAULT_VAL(RST_IRQ_STATUS),
    .TEST_WR(IRQ_STATUS_TEST_WR), .TEST_RD(IRQ_STATUS_TEST_RD),
    .CFG_WR(IRQ_STATUS_CFG_WR), .CFG_RD(IRQ_STATUS_CFG_RD)
  ) irq_status_inst (
    .i_clk, .i_rst_n, .i_wen, .i_ren, .i_cfg_mode, .i_test_mode, .i_addr, .i_wdata,
    .i_lgc_set(i_evt),
    .o_rdata(status_rdata), .o_hit(status_hit), .o_q(status_q)
  );

  // ====================================================================
  // id register, a constant with its own decode
  // ====================================================================
  assign id_hit   = (i_addr == ADDR_ID);
  assign id_rd_ok = i_ren & id_hit & ((i_test_mode & ID_TEST_RD) | (i_cfg_mode & ID_CFG_RD));
  assign id_rdata = id_rd_ok ? CSR_ID_VAL : '0;

  // at most one source is non-zero, so a plain or merges them
  assign o_rdata = ctrl_rdata | irq_en_rdata | status_rdata | scratch_rdata | id_rdata;
  assign o_hit   = ctrl_hit | irq_en_hit | status_hit | scratch_hit | id_hit;

  // any enabled pending status bit
  assign o_irq = |(status_q & irq_en_q);

endmodule

//--- source/csr_rsp_out.sv
/*
 * csr response stage: captures read data and error on a strobe
 * and holds them until the response channel takes them
 */
`timescale 1ns/1ps

module csr_rsp_out
  import csr_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_ren,
  input  logic              i_wen,
  input  logic [CSR_DW-1:0] i_rdata,
  input  logic              i_hit,
  input  logic              i_rsp_ready,
  output logic              o_rsp_valid,
  output logic [CSR_DW-1:0] o_rsp_rdata,
  output logic              o_rsp_err,
  output logic              o_busy
);

  logic strobe;
  logic rsp_done;

  // ====================================================================
  // response handshake
  // ====================================================================

  // either access kind produces exactly one response
  assign strobe   = i_ren | i_wen;
  assign rsp_done = o_rsp_valid & i_rsp_ready;

  // a strobe can only come while the slot is empty,
  // the bus slave holds off requests while busy
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (strobe) begin
      o_rsp_valid <= 1'b1;
    end else if (rsp_done) begin
      o_rsp_valid <= 1'b0;
    end
  end

  // payload, loaded with the strobe and frozen while stalled
  // writes return the merged data too, which is zero
  always_ff @(posedge i_clk) begin
    if (strobe) begin
      o_rsp_rdata <= i_rdata;
      o_rsp_err   <= ~i_hit;
    end
  end

  // slot occupied until the transfer edge
  assign o_busy = o_rsp_valid;

endmodule

//--- source/csr_top.sv
/*
 * csr top: request slave, register bank and response stage
 */
`timescale 1ns/1ps

module csr_top
  import csr_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  // request channel
  input  logic              i_req_valid,
  output logic              o_req_ready,
  input  logic              i_req_write,
  input  logic [CSR_AW-1:0] i_req_addr,
  input  logic [CSR_DW-1:0] i_req_wdata,
  // response channel
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output logic [CSR_DW-1:0] o_rsp_rdata,
  output logic              o_rsp_err,
  // modes and hardware side
  input  logic              i_cfg_mode,
  input  logic              i_test_mode,
  input  logic [CSR_DW-1:0] i_evt,
  output logic [CSR_DW-1:0] o_ctrl,
  output logic              o_irq
);

  // slave to bank
  logic              bus_wen;
  logic              bus_ren;
  logic [CSR_AW-1:0] bus_addr;
  logic [CSR_DW-1:0] bus_wdata;
  // bank to response
  logic [CSR_DW-1:0] bank_rdata;
  logic              bank_hit;
  // response back to slave
  logic              rsp_busy;

  // ====================================================================
  // input side
  // ====================================================================
  csr_bus_slave bus_slave_inst (
    .i_clk, .i_rst_n, .i_req_valid, .i_req_write, .i_req_addr, .i_req_wdata,
    .i_rsp_busy(rsp_busy),
    .o_req_ready,
    .o_wen(bus_wen), .o_ren(bus_ren), .o_addr(bus_addr), .o_wdata(bus_wdata)
  );

  // ====================================================================
  // registers
  // ====================================================================
  csr_reg_bank reg_bank_inst (
    .i_clk, .i_rst_n,
    .i_wen(bus_wen), .i_ren(bus_ren), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .i_cfg_mode, .i_test_mode, .i_evt,
    .o_rdata(bank_rdata), .o_hit(bank_hit), .o_ctrl, .o_irq
  );

  // ====================================================================
  // output side
  // ====================================================================
  csr_rsp_out rsp_out_inst (
    .i_clk, .i_rst_n,
    .i_ren(bus_ren), .i_wen(bus_wen), .i_rdata(bank_rdata), .i_hit(bank_hit),
    .i_rsp_ready,
    .o_rsp_valid, .o_rsp_rdata, .o_rsp_err,
    .o_busy(rsp_busy)
  );

endmodule

//--- source/rw_reg.sv
/*
 * rw register: plain cpu read/write register with its own
 * address decode and mode-gated access
 */
`timescale 1ns/1ps

module rw_reg
  import csr_pkg::*;
#(
  parameter logic [CSR_AW-1:0] REG_ADDR    = '0,
  parameter logic [CSR_DW-1:0] DEFAULT_VAL = '0,
  parameter bit                TEST_WR     = 1'b1,
  parameter bit                TEST_RD     = 1'b1,
  parameter bit                CFG_WR      = 1'b1,
  parameter bit                CFG_RD      = 1'b1
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wen,
  input  logic              i_ren,
  input  logic              i_cfg_mode,
  input  logic              i_test_mode,
  input  logic [CSR_AW-1:0] i_addr,
  input  logic [CSR_DW-1:0] i_wdata,
  output logic [CSR_DW-1:0] o_rdata,
  output logic              o_hit,
  output logic [CSR_DW-1:0] o_q
);

  logic wr_ok;
  logic rd_ok;

  // address match, independent of mode
  assign o_hit = (i_addr == REG_ADDR);

  // access allowed if any active mode grants it
  assign wr_ok = i_wen & o_hit & ((i_test_mode & TEST_WR) | (i_cfg_mode & CFG_WR));
  assign rd_ok = i_ren & o_hit & ((i_test_mode & TEST_RD) | (i_cfg_mode & CFG_RD));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= DEFAULT_VAL;
    end else if (wr_ok) begin
      o_q <= i_wdata;
    end
  end

  // zero unless this register is the one being read
  assign o_rdata = rd_ok ? o_q : '0;

endmodule

//--- source/rwc_reg.sv
/*
 * rwc register: status bits set by hardware, cleared by the cpu
 * writing ones; a set always beats a clear of the same bit
 */
`timescale 1ns/1ps

module rwc_reg
  import csr_pkg::*;
#(
  parameter logic [CSR_AW-1:0] REG_ADDR    = '0,
  parameter logic [CSR_DW-1:0] DEFAULT_VAL = '0,
  parameter bit                TEST_WR     = 1'b1,
  parameter bit                TEST_RD     = 1'b1,
  parameter bit                CFG_WR      = 1'b1,
  parameter bit                CFG_RD      = 1'b1
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wen,
  input  logic              i_ren,
  input  logic              i_cfg_mode,
  input  logic              i_test_mode,
  input  logic [CSR_AW-1:0] i_addr,
  input  logic [CSR_DW-1:0] i_wdata,
  input  logic [CSR_DW-1:0] i_lgc_set,
  output logic [CSR_DW-1:0] o_rdata,
  output logic              o_hit,
  output logic [CSR_DW-1:0] o_q
);

  logic              wr_ok;
  logic              rd_ok;
  logic [CSR_DW-1:0] clr_mask;

  assign o_hit = (i_addr == REG_ADDR);
  assign wr_ok = i_wen & o_hit & ((i_test_mode & TEST_WR) | (i_cfg_mode & CFG_WR));
  assign rd_ok = i_ren & o_hit & ((i_test_mode & TEST_RD) | (i_cfg_mode & CFG_RD));

  // write data ones select bits to clear
  assign clr_mask = wr_ok ? i_wdata : '0;

  // clear first, then or in the hardware sets
  // per bit, so an event and a clear on different bits both land
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= DEFAULT_VAL;
    end else begin
      o_q <= (o_q & ~clr_mask) | i_lgc_set;
    end
  end

  assign o_rdata = rd_ok ? o_q : '0;

endmodule

//--- vlog.f
source/csr_pkg.sv
source/csr_bus_slave.sv
source/rw_reg.sv
source/rwc_reg.sv
source/csr_reg_bank.sv
source/csr_rsp_out.sv
source/csr_top.sv
sim/csr_properties.sv
sim/csr_tb.sv
